// File: hdl/rv_pkg.sv
package rv_pkg;

  // Datapath widths
  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;
  localparam int APB_AW   = 12;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B  // lui
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // RV32I encodings

  localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [2:0] F3_ADD_SUB = 3'h0;
  localparam logic [2:0] F3_SLL     = 3'h1;
  localparam logic [2:0] F3_SLT     = 3'h2;
  localparam logic [2:0] F3_SLTU    = 3'h3;
  localparam logic [2:0] F3_XOR     = 3'h4;
  localparam logic [2:0] F3_SRL_SRA = 3'h5;
  localparam logic [2:0] F3_OR      = 3'h6;
  localparam logic [2:0] F3_AND     = 3'h7;

  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;  // sub and sra

  //////////////////////////////////////////////////////////////////////
  // Host register map

  localparam logic [APB_AW-1:0] ADDR_IMEM_LIMIT = 12'h800;  // End of instruction window
  localparam logic [APB_AW-1:0] ADDR_CTRL       = 12'h800;
  localparam logic [APB_AW-1:0] ADDR_STATUS     = 12'h804;
  localparam logic [APB_AW-1:0] ADDR_PROG_LEN   = 12'h808;
  localparam logic [APB_AW-1:0] ADDR_ILLEGAL    = 12'h80C;
  localparam logic [APB_AW-1:0] ADDR_REG_BASE   = 12'h880;  // x0, then one word per register

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ns

module alu (
  input  rv_pkg::alu_op_e         op,
  input  logic [rv_pkg::XLEN-1:0] a,
  input  logic [rv_pkg::XLEN-1:0] b,
  output logic [rv_pkg::XLEN-1:0] result
);
  import rv_pkg::*;

  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [XLEN-1:0] sra_res;

  assign shamt = b[4:0];  // RV32I shifts use 5 bits only

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign sra_res     = $signed(a) >>> shamt;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_XOR:    result = a ^ b;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = sra_res;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_PASS_B: result = b;  // lui
      default:    result = '0;
    endcase
  end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
  input  logic [rv_pkg::XLEN-1:0]   instr,
  output logic [rv_pkg::REG_AW-1:0] rs1,
  output logic [rv_pkg::REG_AW-1:0] rs2,
  output logic [rv_pkg::REG_AW-1:0] rd,
  output logic [rv_pkg::XLEN-1:0]   imm,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      use_imm,
  output logic                      rd_we,
  output logic                      illegal
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_r_instr;
  logic       is_i_instr;
  logic       is_u_instr;
  logic       f7_base;
  logic       f7_alt;
  logic       base_ok;
  logic       op_ok;
  alu_op_e    op_sel;

  // Field split
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];  // Upper immediate bits for I-type

  assign is_r_instr = opcode == OPC_OP;
  assign is_i_instr = opcode == OPC_OP_IMM;
  assign is_u_instr = opcode == OPC_LUI;

  assign f7_base = funct7 == F7_BASE;
  assign f7_alt  = funct7 == F7_ALT;
  assign base_ok = is_i_instr || f7_base;  // I-type ignores funct7 here

  //////////////////////////////////////////////////////////////////////
  // Operation select

  always_comb begin
    op_sel = ALU_ADD;
    op_ok  = 1'b0;
    if (is_u_instr) begin
      op_sel = ALU_PASS_B;
      op_ok  = 1'b1;
    end else if (is_r_instr || is_i_instr) begin
      op_ok = base_ok;
      unique case (funct3)
        F3_ADD_SUB: begin
          op_sel = (is_r_instr && f7_alt) ? ALU_SUB : ALU_ADD;
          op_ok  = base_ok || (is_r_instr && f7_alt);
        end
        F3_SLL: begin
          op_sel = ALU_SLL;
          op_ok  = f7_base;  // slli needs a clean upper field too
        end
        F3_SRL_SRA: begin
          op_sel = f7_alt ? ALU_SRA : ALU_SRL;
          op_ok  = f7_base || f7_alt;
        end
        F3_SLT:  op_sel = ALU_SLT;
        F3_SLTU: op_sel = ALU_SLTU;
        F3_XOR:  op_sel = ALU_XOR;
        F3_OR:   op_sel = ALU_OR;
        F3_AND:  op_sel = ALU_AND;
      endcase
    end
  end

  // U immediate keeps the low 12 bits clear
  assign imm = is_u_instr ? {instr[31:12], 12'b0} :
                            {{20{instr[31]}}, instr[31:20]};

  assign alu_op  = op_sel;
  assign use_imm = is_i_instr || is_u_instr;
  assign rd_we   = op_ok;
  assign illegal = !op_ok;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      we,
  input  logic [rv_pkg::REG_AW-1:0] waddr,
  input  logic [rv_pkg::XLEN-1:0]   wdata,
  input  logic [rv_pkg::REG_AW-1:0] raddr_a,
  input  logic [rv_pkg::REG_AW-1:0] raddr_b,
  output logic [rv_pkg::XLEN-1:0]   rdata_a,
  output logic [rv_pkg::XLEN-1:0]   rdata_b,
  input  logic [rv_pkg::REG_AW-1:0] host_raddr,
  output logic [rv_pkg::XLEN-1:0]   host_rdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin  // x0 is hardwired
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads
  assign rdata_a    = regs[raddr_a];
  assign rdata_b    = regs[raddr_b];
  assign host_rdata = regs[host_raddr];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (raddr_a == '0 |-> rdata_a == '0) and (host_raddr == '0 |-> host_rdata == '0));

endmodule

// File: hdl/instr_mem.sv
`timescale 1ns/1ns

module instr_mem #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] waddr,
  input  logic [rv_pkg::XLEN-1:0]       wdata,
  input  logic                          re,
  input  logic [$clog2(IMEM_DEPTH)-1:0] raddr,
  output logic [rv_pkg::XLEN-1:0]       rdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] mem [IMEM_DEPTH];

  // Host write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Fetch port, one cycle latency
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: hdl/pc_counter.sv
`timescale 1ns/1ns

module pc_counter #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          pc_clear,
  input  logic                          pc_step,
  input  logic [rv_pkg::XLEN-1:0]       prog_len,
  output logic [$clog2(IMEM_DEPTH)-1:0] pc,
  output logic                          last
);
  import rv_pkg::*;

  localparam int PC_W  = $clog2(IMEM_DEPTH);
  localparam int CNT_W = $clog2(IMEM_DEPTH + 1);  // Holds a full-length count

  logic [CNT_W-1:0] step_cnt;

  always_ff @(posedge clk) begin
    if (rst || pc_clear) begin
      pc       <= '0;
      step_cnt <= '0;
    end else if (pc_step) begin
      pc       <= (pc == PC_W'(IMEM_DEPTH - 1)) ? '0 : pc + 1'b1;
      step_cnt <= step_cnt + 1'b1;
    end
  end

  // High while the final instruction executes
  assign last = (XLEN'(step_cnt) + XLEN'(1)) == prog_len;

  // Host port clamps PROG_LEN, so stepping never runs past memory
  a_pc_range: assert property (@(posedge clk) disable iff (rst)
    pc_step |-> (int'(pc) < IMEM_DEPTH) && (XLEN'(step_cnt) < prog_len));

endmodule

// File: hdl/exec_fsm.sv
`timescale 1ns/1ns

module exec_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start_req,
  input  logic [rv_pkg::XLEN-1:0] prog_len,
  input  logic                    last,
  input  logic                    illegal,
  output logic                    pc_clear,
  output logic                    pc_step,
  output logic                    imem_re,
  output logic                    exec_en,
  output logic                    busy,
  output logic                    done,
  output logic [rv_pkg::XLEN-1:0] illegal_cnt
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    EXEC,
    DONE_ST
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   launch;

  // Start only counts when idle or finished
  assign launch = start_req && (state == IDLE || state == DONE_ST);

  //////////////////////////////////////////////////////////////////////
  // Sequencing

  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE, DONE_ST: begin
        if (launch) begin
          state_nxt = (prog_len == '0) ? DONE_ST : FETCH;  // Empty program
        end
      end
      FETCH: state_nxt = EXEC;
      EXEC:  state_nxt = last ? DONE_ST : FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Illegal instruction counter
  always_ff @(posedge clk) begin
    if (rst || launch) begin
      illegal_cnt <= '0;
    end else if (exec_en && illegal) begin
      illegal_cnt <= illegal_cnt + 1'b1;
    end
  end

  assign pc_clear = launch;
  assign imem_re  = state == FETCH;
  assign exec_en  = state == EXEC;
  assign pc_step  = exec_en;  // Advance once per executed word
  assign busy     = (state == FETCH) || (state == EXEC);
  assign done     = state == DONE_ST;

  // Length must hold still under a running program
  a_len_stable: assert property (@(posedge clk) disable iff (rst)
    busy |-> $stable(prog_len));

endmodule

// File: hdl/apb_host_port.sv
`timescale 1ns/1ns

module apb_host_port #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::APB_AW-1:0]     paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [rv_pkg::XLEN-1:0]       pwdata,
  output logic [rv_pkg::XLEN-1:0]       prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          start_req,
  output logic [rv_pkg::XLEN-1:0]       prog_len_q,
  output logic                          imem_we,
  output logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr,
  output logic [rv_pkg::XLEN-1:0]       imem_wdata,
  output logic [rv_pkg::REG_AW-1:0]     host_raddr,
  input  logic [rv_pkg::XLEN-1:0]       host_rdata,
  input  logic                          busy,
  input  logic                          done,
  input  logic [rv_pkg::XLEN-1:0]       illegal_cnt
);
  import rv_pkg::*;

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  logic access;
  logic aligned;
  logic hit_imem;
  logic hit_ctrl;
  logic hit_status;
  logic hit_plen;
  logic hit_illegal;
  logic hit_reg;
  logic wr_err;
  logic rd_err;
  logic plen_we;

  //////////////////////////////////////////////////////////////////////
  // Address decode

  assign access  = psel && penable;  // Access phase
  assign aligned = paddr[1:0] == 2'b00;

  assign hit_imem = aligned && (paddr < ADDR_IMEM_LIMIT) &&
                    (32'(paddr[APB_AW-1:2]) < IMEM_DEPTH);
  assign hit_ctrl    = paddr == ADDR_CTRL;
  assign hit_status  = paddr == ADDR_STATUS;
  assign hit_plen    = paddr == ADDR_PROG_LEN;
  assign hit_illegal = paddr == ADDR_ILLEGAL;
  assign hit_reg     = aligned && (paddr[APB_AW-1:7] == ADDR_REG_BASE[APB_AW-1:7]);

  // Memory and length are locked during a run
  always_comb begin
    wr_err = 1'b1;
    if (hit_imem || hit_plen) begin
      wr_err = busy;
    end else if (hit_ctrl) begin
      wr_err = 1'b0;
    end
  end

  assign rd_err  = !(hit_ctrl || hit_status || hit_plen || hit_illegal || hit_reg);
  assign pslverr = access && (pwrite ? wr_err : rd_err);
  assign pready  = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Write side

  assign imem_we    = access && pwrite && hit_imem && !busy;
  assign imem_waddr = paddr[IMEM_AW+1:2];
  assign imem_wdata = pwdata;
  assign start_req  = access && pwrite && hit_ctrl && pwdata[0];
  assign plen_we    = access && pwrite && hit_plen && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      prog_len_q <= '0;
    end else if (plen_we) begin
      // Never longer than the memory
      prog_len_q <= (pwdata > XLEN'(IMEM_DEPTH)) ? XLEN'(IMEM_DEPTH) : pwdata;
    end
  end

  // Read side
  assign host_raddr = paddr[6:2];

  always_comb begin
    prdata = '0;
    if (hit_status) begin
      prdata = {{(XLEN-2){1'b0}}, done, busy};
    end else if (hit_plen) begin
      prdata = prog_len_q;
    end else if (hit_illegal) begin
      prdata = illegal_cnt;
    end else if (hit_reg) begin
      prdata = host_rdata;
    end
  end

  // Setup phase is always followed by its access phase
  a_setup_then_access: assert property (@(posedge clk) disable iff (rst)
    psel && !penable |=> psel && penable);

endmodule

// File: hdl/rv_apb_core.sv
`timescale 1ns/1ns

module rv_apb_core #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::APB_AW-1:0] paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [rv_pkg::XLEN-1:0]   pwdata,
  output logic [rv_pkg::XLEN-1:0]   prdata,
  output logic                      pready,
  output logic                      pslverr
);
  import rv_pkg::*;

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  // Host side
  logic               start_req;
  logic [XLEN-1:0]    prog_len_q;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_waddr;
  logic [XLEN-1:0]    imem_wdata;
  logic [REG_AW-1:0]  host_raddr;
  logic [XLEN-1:0]    host_rdata;
  logic               busy;
  logic               done;
  logic [XLEN-1:0]    illegal_cnt;

  // Sequencer and fetch
  logic               pc_clear;
  logic               pc_step;
  logic               imem_re;
  logic               exec_en;
  logic [IMEM_AW-1:0] pc;
  logic               last;
  logic [XLEN-1:0]    instr;

  // Datapath
  logic [REG_AW-1:0]  rs1;
  logic [REG_AW-1:0]  rs2;
  logic [REG_AW-1:0]  rd;
  logic [XLEN-1:0]    imm;
  alu_op_e            alu_op;
  logic               use_imm;
  logic               rd_we;
  logic               illegal;
  logic [XLEN-1:0]    rs1_data;
  logic [XLEN-1:0]    rs2_data;
  logic [XLEN-1:0]    alu_b;
  logic [XLEN-1:0]    result;

  assign alu_b = use_imm ? imm : rs2_data;

  //////////////////////////////////////////////////////////////////////
  // Blocks

  apb_host_port #(.IMEM_DEPTH(IMEM_DEPTH)) host_i (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .start_req, .prog_len_q, .imem_we, .imem_waddr, .imem_wdata,
    .host_raddr, .host_rdata, .busy, .done, .illegal_cnt
  );

  exec_fsm fsm_i (
    .clk, .rst, .start_req, .prog_len(prog_len_q), .last, .illegal,
    .pc_clear, .pc_step, .imem_re, .exec_en, .busy, .done, .illegal_cnt
  );

  pc_counter #(.IMEM_DEPTH(IMEM_DEPTH)) pc_i (
    .clk, .rst, .pc_clear, .pc_step, .prog_len(prog_len_q), .pc, .last
  );

  instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) imem_i (
    .clk, .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
    .re(imem_re), .raddr(pc), .rdata(instr)
  );

  instr_decoder dec_i (
    .instr, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm, .rd_we, .illegal
  );

  alu alu_i (
    .op(alu_op), .a(rs1_data), .b(alu_b), .result
  );

  reg_file rf_i (
    .clk, .rst,
    .we(rd_we && exec_en),  // Only in EXEC
    .waddr(rd), .wdata(result),
    .raddr_a(rs1), .raddr_b(rs2), .rdata_a(rs1_data), .rdata_b(rs2_data),
    .host_raddr, .host_rdata
  );

endmodule

// File: dv/rv_apb_core_tb.sv
`timescale 1ns/1ns

module rv_apb_core_tb;
  import rv_pkg::*;

  localparam int IMEM_DEPTH      = 64;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (IMEM_DEPTH * 2 + 200);
  localparam int POLL_LIMIT      = IMEM_DEPTH * 2 + 16;

  logic              clk;
  logic              rst;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [XLEN-1:0]   pwdata;
  logic [XLEN-1:0]   prdata;
  logic              pready;
  logic              pslverr;

  logic [XLEN-1:0] ref_regs [NUM_REGS];  // Register model
  int              ref_illegal;
  logic [XLEN-1:0] prog [$];
  int              errors;
  int              checks;

  rv_apb_core #(.IMEM_DEPTH(IMEM_DEPTH)) dut_i (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Errors: %0d of %0d checks", errors, checks);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and APB driver

  task automatic check_eq(input string what, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // Setup cycle, then one access cycle since pready is tied high
  task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                          input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata,
                          output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // Mid access phase
    rdata = prdata;
    err   = pslverr;
    check_eq("pready in access phase", XLEN'(pready), 32'h1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_ok(input logic [APB_AW-1:0] addr, input logic [XLEN-1:0] data,
                          input string what);
    logic [XLEN-1:0] rdata;
    logic            err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_eq({what, " pslverr"}, XLEN'(err), '0);
  endtask

  task automatic read_check(input logic [APB_AW-1:0] addr, input logic [XLEN-1:0] exp,
                            input string what);
    logic [XLEN-1:0] rdata;
    logic            err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_eq({what, " pslverr"}, XLEN'(err), '0);
    check_eq(what, rdata, exp);
  endtask

  task automatic expect_slverr(input logic write, input logic [APB_AW-1:0] addr,
                               input logic [XLEN-1:0] data, input string what);
    logic [XLEN-1:0] rdata;
    logic            err;
    apb_xfer(write, addr, data, rdata, err);
    check_eq({what, " pslverr"}, XLEN'(err), 32'h1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Encodings and reference model

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic void model_exec(input logic [31:0] ins);
    logic [6:0]             opc;
    logic [2:0]             f3;
    logic [6:0]             f7;
    logic                   is_op;
    logic                   ok;
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic signed [XLEN-1:0] sa;
    logic [XLEN-1:0]        res;
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    is_op = opc == OPC_OP;
    a     = ref_regs[ins[19:15]];
    sa    = a;
    b     = is_op ? ref_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    res   = '0;
    ok    = 1'b0;
    if (opc == OPC_LUI) begin
      res = {ins[31:12], 12'h000};
      ok  = 1'b1;
    end else if (is_op || opc == OPC_OP_IMM) begin
      ok = !is_op || f7 == 7'h00;  // funct7 only matters for R-type and shifts
      case (f3)
        3'd0: begin
          res = (is_op && f7 == 7'h20) ? a - b : a + b;
          ok  = ok || (is_op && f7 == 7'h20);
        end
        3'd1: begin
          res = a << b[4:0];
          ok  = f7 == 7'h00;
        end
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: begin
          if (f7 == 7'h20) begin
            res = sa >>> b[4:0];
          end else begin
            res = a >> b[4:0];
          end
          ok = f7 == 7'h00 || f7 == 7'h20;
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
    end
    if (!ok) begin
      ref_illegal++;
    end else if (ins[11:7] != 5'd0) begin
      ref_regs[ins[11:7]] = res;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Program sequencing

  task automatic check_regs(input string name);
    for (int i = 0; i < NUM_REGS; i++) begin
      read_check(APB_AW'(ADDR_REG_BASE + 4 * i), ref_regs[i], $sformatf("%s x%0d", name, i));
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      write_ok(APB_AW'(4 * i), prog[i], "instruction write");
    end
  endtask

  task automatic start_program(input int n);
    write_ok(ADDR_PROG_LEN, XLEN'(n), "PROG_LEN write");
    ref_illegal = 0;  // Count restarts with each run
    for (int i = 0; i < n; i++) begin
      model_exec(prog[i]);
    end
    write_ok(ADDR_CTRL, 32'h1, "start");
  endtask

  task automatic wait_done();
    logic [XLEN-1:0] status;
    logic            err;
    int              polls;
    status = '0;
    polls  = 0;
    while (status[1] !== 1'b1 && polls < POLL_LIMIT) begin
      apb_xfer(1'b0, ADDR_STATUS, '0, status, err);
      polls++;
    end
    if (status[1] !== 1'b1) begin
      errors++;
      $display("Done never rose at %0t ns after %0d status polls", $time, polls);
    end else begin
      check_eq("STATUS after run", status, 32'h2);  // Busy already low
    end
  endtask

  task automatic finish_program(input string name);
    wait_done();
    check_regs(name);
    read_check(ADDR_ILLEGAL, XLEN'(ref_illegal), {name, " ILLEGAL"});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic check_reset_state();
    read_check(ADDR_STATUS, '0, "reset STATUS");
    read_check(ADDR_ILLEGAL, '0, "reset ILLEGAL");
    read_check(ADDR_PROG_LEN, '0, "reset PROG_LEN");
    check_regs("reset");
  endtask

  task automatic run_r_type_ops();
    prog.delete();
    prog.push_back(enc_u(20'($urandom), 5'd1));
    prog.push_back(enc_i(12'($urandom), 5'd1, F3_ADD_SUB, 5'd1));
    prog.push_back(enc_u(20'($urandom) | 20'h80000, 5'd2));  // Negative operand
    prog.push_back(enc_i(12'($urandom), 5'd2, F3_ADD_SUB, 5'd2));
    prog.push_back(enc_i(12'($urandom % 32), 5'd0, F3_ADD_SUB, 5'd3));
    prog.push_back(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd5));
    prog.push_back(enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd6));
    prog.push_back(enc_r(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd7));
    prog.push_back(enc_r(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd8));
    prog.push_back(enc_r(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd9));
    prog.push_back(enc_r(F7_BASE, 5'd3, 5'd1, F3_SLL, 5'd10));
    prog.push_back(enc_r(F7_BASE, 5'd3, 5'd2, F3_SRL_SRA, 5'd11));
    prog.push_back(enc_r(F7_ALT, 5'd3, 5'd2, F3_SRL_SRA, 5'd12));
    prog.push_back(enc_r(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd13));
    prog.push_back(enc_r(F7_BASE, 5'd1, 5'd2, F3_SLTU, 5'd14));
    prog.push_back(enc_r(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd15));
    load_program();
    start_program(prog.size());
    finish_program("R-type");
  endtask

  task automatic run_i_type_ops();
    prog.delete();
    prog.push_back(enc_u(20'($urandom) & 20'h7ffff, 5'd4));  // Positive source
    prog.push_back(enc_i(12'($urandom), 5'd4, F3_ADD_SUB, 5'd4));
    prog.push_back(enc_u(20'($urandom) | 20'h80000, 5'd5));  // Negative source
    prog.push_back(enc_i(12'($urandom), 5'd5, F3_ADD_SUB, 5'd5));
    prog.push_back(enc_i(12'($urandom) | 12'h800, 5'd4, F3_ADD_SUB, 5'd16));
    prog.push_back(enc_i(12'($urandom), 5'd5, F3_XOR, 5'd17));
    prog.push_back(enc_i(12'($urandom), 5'd4, F3_OR, 5'd18));
    prog.push_back(enc_i(12'($urandom) | 12'h800, 5'd5, F3_AND, 5'd19));
    prog.push_back(enc_i({F7_BASE, 5'($urandom)}, 5'd4, F3_SLL, 5'd20));
    prog.push_back(enc_i({F7_BASE, 5'($urandom)}, 5'd5, F3_SRL_SRA, 5'd21));
    prog.push_back(enc_i({F7_ALT, 5'($urandom)}, 5'd5, F3_SRL_SRA, 5'd22));
    prog.push_back(enc_i(12'($urandom), 5'd5, F3_SLT, 5'd23));
    prog.push_back(enc_i(12'($urandom) | 12'h800, 5'd4, F3_SLTU, 5'd24));
    load_program();
    start_program(prog.size());
    finish_program("I-type");
  endtask

  task automatic x0_and_illegal();
    prog.delete();
    prog.push_back(enc_i(12'h07b, 5'd1, F3_ADD_SUB, 5'd0));
    prog.push_back(enc_u(20'habcde, 5'd0));
    prog.push_back(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd0));
    prog.push_back({12'h004, 5'd1, 3'b010, 5'd25, 7'b0000011});  // lw
    prog.push_back({7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011});  // beq
    prog.push_back(enc_r(7'h01, 5'd2, 5'd1, F3_ADD_SUB, 5'd25));
    prog.push_back(enc_r(F7_ALT, 5'd2, 5'd1, F3_XOR, 5'd25));
    prog.push_back(enc_i({F7_ALT, 5'd3}, 5'd1, F3_SLL, 5'd25));
    prog.push_back(enc_i({7'h10, 5'd3}, 5'd1, F3_SRL_SRA, 5'd25));
    prog.push_back(enc_i(12'h007, 5'd0, F3_ADD_SUB, 5'd27));
    load_program();
    start_program(prog.size());
    finish_program("x0 and illegal");
    read_check(ADDR_ILLEGAL, 32'd6, "six illegal encodings");
  endtask

  task automatic apb_error_cases();
    logic [XLEN-1:0] status;
    logic            err;
    prog.delete();
    for (int i = 0; i < 20; i++) begin
      prog.push_back(enc_i(12'h001, 5'd26, F3_ADD_SUB, 5'd26));  // Counts each pass
    end
    prog.push_back(enc_u(20'h12345, 5'd28));
    load_program();
    start_program(prog.size());
    expect_slverr(1'b1, APB_AW'(4 * 15), enc_u(20'hfffff, 5'd26), "busy memory write");
    expect_slverr(1'b1, ADDR_PROG_LEN, 32'd2, "busy PROG_LEN write");
    write_ok(ADDR_CTRL, 32'h1, "start while busy");
    apb_xfer(1'b0, ADDR_STATUS, '0, status, err);
    check_eq("STATUS while running", status, 32'h1);
    expect_slverr(1'b0, 12'h810, '0, "unmapped read");
    expect_slverr(1'b1, 12'h9fc, 32'hdead, "unmapped write");
    finish_program("APB errors");
    read_check(ADDR_PROG_LEN, 32'd21, "PROG_LEN after blocked write");
    expect_slverr(1'b0, 12'h806, '0, "misaligned read");
    expect_slverr(1'b1, 12'h100, 32'h0, "write past memory");
    expect_slverr(1'b1, ADDR_STATUS, 32'h3, "STATUS write");
  endtask

  task automatic empty_then_second_program();
    prog.delete();
    start_program(0);
    finish_program("empty program");
    prog.push_back(enc_u(20'($urandom), 5'd29));
    prog.push_back(enc_i(12'($urandom), 5'd29, F3_ADD_SUB, 5'd29));
    prog.push_back(enc_r(F7_ALT, 5'd1, 5'd29, F3_ADD_SUB, 5'd30));
    prog.push_back(enc_i(12'hfff, 5'd30, F3_XOR, 5'd31));  // Bitwise not
    load_program();
    start_program(prog.size());
    finish_program("second program");
  endtask

  initial begin : main
    rst         = 1'b1;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    errors      = 0;
    checks      = 0;
    ref_illegal = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    void'($urandom(23));
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    check_reset_state();
    run_r_type_ops();
    run_i_type_ops();
    x0_and_illegal();
    apb_error_cases();
    empty_then_second_program();

    $display("Errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: rv_apb_core.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/instr_mem.sv
hdl/pc_counter.sv
hdl/exec_fsm.sv
hdl/apb_host_port.sv
hdl/rv_apb_core.sv
dv/rv_apb_core_tb.sv

// File: Bender.yml
package:
  name: rv_apb_core

sources:
  - hdl/rv_pkg.sv
  - hdl/alu.sv
  - hdl/instr_decoder.sv
  - hdl/reg_file.sv
  - hdl/instr_mem.sv
  - hdl/pc_counter.sv
  - hdl/exec_fsm.sv
  - hdl/apb_host_port.sv
  - hdl/rv_apb_core.sv
  - target: simulation
    files:
      - dv/rv_apb_core_tb.sv
